//--- src/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

	////////////////////
	// Widths

	// APB byte address
	typedef logic [8:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	// SCK half-period in APB cycles
	typedef logic [15:0] clkdiv_t;
	// Up to 256 bytes, so 9 bits
	typedef logic [8:0] burst_len_t;
	// 64 words in the receive buffer
	typedef logic [5:0] buf_idx_t;

	////////////////////
	// Register map

	// Writable registers on 0x20 boundaries
	localparam addr_t REG_CLK_DIV = 9'h000;
	localparam addr_t REG_DATA = 9'h020;
	localparam addr_t REG_CS_N = 9'h040;
	localparam addr_t REG_STATUS = 9'h060;
	localparam addr_t REG_BURST_RDLEN = 9'h0A0;
	localparam addr_t REG_QUAD_CAP = 9'h0C0;
	localparam addr_t REG_QBURST_RDLEN = 9'h0E0;
	// Buffer window 0x100 to 0x1FC
	localparam addr_t REG_RXBUF = 9'h100;

	localparam int MAX_BURST = 256;
	localparam clkdiv_t CLKDIV_RESET = 16'd100;

	////////////////////
	// Bundles

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		addr_t paddr;
		word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// One byte shift request
	typedef struct packed {
		logic start;
		logic quad;
		byte_t tx_data;
	} shift_cmd_t;

	// Pins toward the flash
	typedef struct packed {
		logic sck;
		logic cs_n;
		logic [3:0] dq_out;
		logic [3:0] dq_oe;
	} qspi_out_t;

	////////////////////
	// FSM states

	typedef enum logic [1:0] {
		BURST_IDLE,
		BURST_SINGLE,
		BURST_QUAD
	} burst_state_t;

	typedef enum logic [1:0] {
		SH_IDLE,
		SH_LOW,
		SH_HIGH
	} shift_state_t;

endpackage

`default_nettype wire

//--- src/qspi_regs.sv
`default_nettype none

module qspi_regs #(
	parameter qspi_pkg::clkdiv_t CLKDIV_RESET = qspi_pkg::CLKDIV_RESET
) (
	input wire logic apb,
	input wire logic rst_n,

	// APB completer side
	input wire qspi_pkg::apb_req_t req,
	output qspi_pkg::apb_rsp_t rsp,

	// Controller status
	input wire logic busy,
	input wire logic burst_active,
	input wire qspi_pkg::byte_t rx_data,
	input wire qspi_pkg::word_t buf_word,

	// Commands out
	output qspi_pkg::shift_cmd_t cmd_req,
	output logic burst_start,
	output qspi_pkg::burst_len_t burst_len,
	output logic burst_quad,
	output qspi_pkg::buf_idx_t buf_idx,
	output qspi_pkg::clkdiv_t clkdiv,
	output logic cs_n
);
	import qspi_pkg::*;

	logic access;
	logic busy_all;
	logic in_buf;
	logic clkdiv_we;
	logic cs_we;

	////////////////////
	// Access decode

	// No wait states, access phase completes at once
	assign access = req.psel & req.penable;
	assign busy_all = busy | burst_active;

	// Upper half of the map is the buffer window
	assign in_buf = req.paddr[8];

	// Word select inside the window
	assign buf_idx = req.paddr[7:2];

	// Either burst register selects the lane mode
	assign burst_quad = (req.paddr == REG_QBURST_RDLEN);

	// Clamp oversized bursts
	always_comb begin
		if (req.pwdata > word_t'(MAX_BURST)) begin
			burst_len = burst_len_t'(MAX_BURST);
		end else begin
			burst_len = req.pwdata[8:0];
		end
	end

	////////////////////
	// Read mux and write checks

	always_comb begin
		rsp.pready = access;
		rsp.prdata = '0;
		rsp.pslverr = 1'b0;

		// DATA write payload, single lane only
		cmd_req.start = 1'b0;
		cmd_req.quad = 1'b0;
		cmd_req.tx_data = req.pwdata[7:0];

		burst_start = 1'b0;
		clkdiv_we = 1'b0;
		cs_we = 1'b0;

		if (access && req.pwrite) begin
			if (in_buf) begin
				// Buffer is read only
				rsp.pslverr = 1'b1;
			end else begin
				case (req.paddr)
					REG_CLK_DIV: clkdiv_we = 1'b1;
					REG_CS_N: cs_we = 1'b1;

					// Kick off one byte
					REG_DATA: begin
						if (busy_all) begin
							rsp.pslverr = 1'b1;
						end else begin
							cmd_req.start = 1'b1;
						end
					end

					// Zero length starts nothing
					REG_BURST_RDLEN, REG_QBURST_RDLEN: begin
						if (busy_all) begin
							rsp.pslverr = 1'b1;
						end else begin
							burst_start = (req.pwdata != '0);
						end
					end

					// Status, quad cap and unmapped
					default: rsp.pslverr = 1'b1;
				endcase
			end
		end else if (access) begin
			if (in_buf) begin
				rsp.prdata = buf_word;
			end else begin
				case (req.paddr)
					REG_CLK_DIV: rsp.prdata = {16'h0000, clkdiv};
					REG_DATA: rsp.prdata = {24'h000000, rx_data};
					REG_CS_N: rsp.prdata = {31'h0, cs_n};
					REG_STATUS: rsp.prdata = {31'h0, busy_all};
					REG_QUAD_CAP: rsp.prdata = 32'h1;

					// Write-only length registers read zero
					REG_BURST_RDLEN, REG_QBURST_RDLEN: rsp.prdata = '0;

					default: rsp.pslverr = 1'b1;
				endcase
			end
		end
	end

	////////////////////
	// Divider and chip select

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			clkdiv <= CLKDIV_RESET;
			// Deselected out of reset
			cs_n <= 1'b1;
		end else begin
			if (clkdiv_we) begin
				clkdiv <= req.pwdata[15:0];
			end
			if (cs_we) begin
				cs_n <= req.pwdata[0];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/qspi_burst_capture.sv
`default_nettype none

module qspi_burst_capture #(
	parameter int BUF_WORDS = 64
) (
	input wire logic apb,
	input wire logic rst_n,

	// From the register block
	input wire qspi_pkg::shift_cmd_t cmd_req,
	input wire logic burst_start,
	input wire qspi_pkg::burst_len_t burst_len,
	input wire logic burst_quad,
	input wire qspi_pkg::buf_idx_t buf_idx,

	// From the shifter
	input wire logic done,
	input wire qspi_pkg::byte_t rx_data,

	output qspi_pkg::shift_cmd_t cmd,
	output logic burst_active,
	output qspi_pkg::word_t buf_word
);
	import qspi_pkg::*;

	burst_state_t state;
	burst_len_t remaining;
	logic [1:0] byte_pos;
	word_t word_acc;
	buf_idx_t wr_ptr;

	logic byte_in;
	logic last_byte;
	logic wr_en;
	word_t wr_data;

	// Receive buffer
	word_t buf_mem [BUF_WORDS];

	assign burst_active = (state != BURST_IDLE);

	////////////////////
	// Shift command

	assign byte_in = burst_active & done;
	assign last_byte = (remaining == burst_len_t'(1));

	always_comb begin
		case (state)
			BURST_IDLE: begin
				if (burst_start) begin
					// First burst byte goes out right away
					cmd.start = 1'b1;
					cmd.quad = burst_quad;
					cmd.tx_data = '0;
				end else begin
					cmd = cmd_req;
				end
			end
			default: begin
				// Back to back, next shift off each done
				cmd.start = byte_in & ~last_byte;
				cmd.quad = (state == BURST_QUAD);
				cmd.tx_data = '0;
			end
		endcase
	end

	////////////////////
	// Byte packing

	// Little endian, upper bytes still zero on a short word
	always_comb begin
		wr_data = word_acc;
		wr_data[8*byte_pos +: 8] = rx_data;
	end

	// Full word or final byte
	assign wr_en = byte_in & ((byte_pos == 2'd3) | last_byte);

	always_ff @(posedge apb) begin
		if (wr_en) begin
			buf_mem[wr_ptr] <= wr_data;
		end
	end

	// Combinational read port for APB
	assign buf_word = buf_mem[buf_idx];

	////////////////////
	// Burst FSM

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			state <= BURST_IDLE;
			remaining <= '0;
			byte_pos <= '0;
			word_acc <= '0;
			wr_ptr <= '0;
		end else begin
			case (state)
				BURST_IDLE: begin
					if (burst_start) begin
						state <= burst_quad ? BURST_QUAD : BURST_SINGLE;
						remaining <= burst_len;
						byte_pos <= '0;
						word_acc <= '0;
						wr_ptr <= '0;
					end
				end
				default: begin
					if (byte_in) begin
						remaining <= remaining - burst_len_t'(1);
						byte_pos <= byte_pos + 2'd1;
						// Start a clean word after each store
						word_acc <= wr_en ? '0 : wr_data;
						if (wr_en) begin
							wr_ptr <= wr_ptr + buf_idx_t'(1);
						end
						if (last_byte) begin
							state <= BURST_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/qspi_shifter.sv
`default_nettype none

module qspi_shifter (
	input wire logic apb,
	input wire logic rst_n,

	input wire qspi_pkg::clkdiv_t clkdiv,
	input wire qspi_pkg::shift_cmd_t cmd,
	input wire logic [3:0] dq_in,
	input wire logic cs_n,

	output qspi_pkg::qspi_out_t qspi,
	output logic done,
	output qspi_pkg::byte_t rx_data,
	output logic busy
);
	import qspi_pkg::*;

	shift_state_t state;
	clkdiv_t div_cnt;
	// Sample edges left, minus one
	logic [2:0] bit_cnt;
	logic quad_r;
	byte_t tx_sr;
	byte_t rx_sr;

	logic half_done;
	logic load;
	logic rise;
	logic fall;
	logic last;
	logic oe_single;

	////////////////////
	// Edge decode

	// Divider of 0 behaves as 1
	assign half_done = ({1'b0, div_cnt} + 17'd1) >= {1'b0, clkdiv};

	assign load = (state == SH_IDLE) & cmd.start;
	assign rise = (state == SH_LOW) & half_done;
	assign fall = (state == SH_HIGH) & half_done;
	assign last = (bit_cnt == 3'd0);

	// Done cycle still counts as busy
	assign busy = (state != SH_IDLE) | done;

	////////////////////
	// Pins

	// Only single lane drives MOSI, quad lanes are inputs
	assign oe_single = (state != SH_IDLE) & ~quad_r;

	assign qspi.sck = (state == SH_HIGH);
	assign qspi.cs_n = cs_n;
	assign qspi.dq_out = {3'b000, tx_sr[7] & oe_single};
	assign qspi.dq_oe = {3'b000, oe_single};

	////////////////////
	// Shift registers

	always_ff @(posedge apb) begin
		if (load) begin
			tx_sr <= cmd.tx_data;
		end else if (fall && !last) begin
			// Next bit set up while SCK low
			tx_sr <= {tx_sr[6:0], 1'b0};
		end

		// Sample on rising SCK, MSB or high nibble first
		if (rise) begin
			if (quad_r) begin
				rx_sr <= {rx_sr[3:0], dq_in};
			end else begin
				rx_sr <= {rx_sr[6:0], dq_in[1]};
			end
		end
	end

	////////////////////
	// SCK FSM

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			state <= SH_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			quad_r <= 1'b0;
			done <= 1'b0;
			rx_data <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				SH_IDLE: begin
					if (load) begin
						state <= SH_LOW;
						div_cnt <= '0;
						// 8 bits or 2 nibbles
						bit_cnt <= cmd.quad ? 3'd1 : 3'd7;
						quad_r <= cmd.quad;
					end
				end
				SH_LOW: begin
					if (half_done) begin
						state <= SH_HIGH;
						div_cnt <= '0;
					end else begin
						div_cnt <= div_cnt + clkdiv_t'(1);
					end
				end
				SH_HIGH: begin
					if (half_done) begin
						div_cnt <= '0;
						if (last) begin
							state <= SH_IDLE;
							done <= 1'b1;
							rx_data <= rx_sr;
						end else begin
							state <= SH_LOW;
							bit_cnt <= bit_cnt - 3'd1;
						end
					end else begin
						div_cnt <= div_cnt + clkdiv_t'(1);
					end
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/qspi_host.sv
`default_nettype none

module qspi_host #(
	parameter qspi_pkg::clkdiv_t CLKDIV_RESET = qspi_pkg::CLKDIV_RESET,
	parameter int BUF_WORDS = 64
) (
	input wire logic apb,
	input wire logic rst_n,

	// APB bus
	input wire qspi_pkg::apb_req_t req,
	output qspi_pkg::apb_rsp_t rsp,

	// Flash pins
	output qspi_pkg::qspi_out_t qspi,
	input wire logic [3:0] dq_in
);
	import qspi_pkg::*;

	////////////////////
	// Internal nets

	shift_cmd_t cmd_req;
	shift_cmd_t cmd;
	logic burst_start;
	burst_len_t burst_len;
	logic burst_quad;
	buf_idx_t buf_idx;
	word_t buf_word;
	clkdiv_t clkdiv;
	logic cs_n;
	logic busy;
	logic burst_active;
	logic done;
	byte_t rx_data;

	// Register map and APB decode
	qspi_regs #(
		.CLKDIV_RESET(CLKDIV_RESET)
	) qspi_regs_i (
		.apb(apb),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp),
		.busy(busy),
		.burst_active(burst_active),
		.rx_data(rx_data),
		.buf_word(buf_word),
		.cmd_req(cmd_req),
		.burst_start(burst_start),
		.burst_len(burst_len),
		.burst_quad(burst_quad),
		.buf_idx(buf_idx),
		.clkdiv(clkdiv),
		.cs_n(cs_n)
	);

	// Burst sequencing and receive buffer
	qspi_burst_capture #(
		.BUF_WORDS(BUF_WORDS)
	) qspi_burst_capture_i (
		.apb(apb),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.burst_start(burst_start),
		.burst_len(burst_len),
		.burst_quad(burst_quad),
		.buf_idx(buf_idx),
		.done(done),
		.rx_data(rx_data),
		.cmd(cmd),
		.burst_active(burst_active),
		.buf_word(buf_word)
	);

	// SCK and lanes
	qspi_shifter qspi_shifter_i (
		.apb(apb),
		.rst_n(rst_n),
		.clkdiv(clkdiv),
		.cmd(cmd),
		.dq_in(dq_in),
		.cs_n(cs_n),
		.qspi(qspi),
		.done(done),
		.rx_data(rx_data),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- dv/qspi_flash_model.sv
`default_nettype none

module qspi_flash_model (
	input wire logic sck,
	input wire logic cs_n,
	input wire logic mosi,
	input wire logic quad,

	// Lanes back toward the host
	output logic [3:0] dq,
	output int byte_count,
	output logic [7:0] mosi_byte
);

	// Falling SCK edges since time zero
	int edges = 0;
	// Edge count when the target was last selected
	int base = 0;

	int pos;
	int per_byte;
	logic [7:0] cur;
	logic [7:0] shifted;

	////////////////////
	// Edge tracking

	always @(negedge sck) begin
		edges <= edges + 1;
	end

	// Select restarts the byte sequence
	always @(negedge cs_n) begin
		base <= edges;
	end

	////////////////////
	// Read data

	// Byte n of the sequence is n XOR 0xA5
	always_comb begin
		pos = edges - base;
		per_byte = quad ? 2 : 8;
		byte_count = pos / per_byte;
		cur = byte_count[7:0] ^ 8'hA5;
		shifted = cur;
		if (quad) begin
			// High nibble first on all lanes
			dq = (pos % 2 == 0) ? cur[7:4] : cur[3:0];
		end else begin
			// MSB first on dq[1]
			shifted = cur << (pos % 8);
			dq = {2'b00, shifted[7], 1'b0};
		end
	end

	////////////////////
	// MOSI capture

	// Host sets up on falling SCK, so rising edge is safe
	always @(posedge sck) begin
		if (!cs_n && !quad) begin
			mosi_byte <= {mosi_byte[6:0], mosi};
		end
	end

endmodule

`default_nettype wire

//--- dv/qspi_host_tb.sv
`default_nettype none

module qspi_host_tb;
	import qspi_pkg::*;

	localparam clkdiv_t DIV_RESET = 16'd100;
	// APB cycles allowed for pready
	localparam int TIMEOUT_CYCLES = 16;
	// Status reads allowed before a transfer counts as stuck
	localparam int IDLE_POLLS = 20000;

	logic apb = 1'b0;
	logic rst_n;
	apb_req_t req;
	apb_rsp_t rsp;
	qspi_out_t qspi;
	logic [3:0] dq_in;

	// Flash model side
	logic flash_quad;
	int flash_bytes;
	byte_t flash_mosi;

	int check_errors = 0;
	int oe_errors = 0;
	int timeouts = 0;
	int sck_rises = 0;
	word_t lcg_state = 32'd64521;

	qspi_host #(
		.CLKDIV_RESET(DIV_RESET),
		.BUF_WORDS(64)
	) qspi_host_i (
		.apb(apb),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp),
		.qspi(qspi),
		.dq_in(dq_in)
	);

	qspi_flash_model flash_i (
		.sck(qspi.sck),
		.cs_n(qspi.cs_n),
		.mosi(qspi.dq_out[0]),
		.quad(flash_quad),
		.dq(dq_in),
		.byte_count(flash_bytes),
		.mosi_byte(flash_mosi)
	);

	always #50 apb = ~apb;

	////////////////////
	// SCK monitor

	// Lane directions on every SCK period
	// Quad lanes stay inputs, single lane drives only MOSI
	always @(posedge qspi.sck) begin
		sck_rises <= sck_rises + 1;
		assert (qspi.dq_oe == (flash_quad ? 4'b0000 : 4'b0001)) else begin
			oe_errors <= oe_errors + 1;
			$display("CHECK FAILED at %0t: dq_oe %b with quad mode %b",
				$time, qspi.dq_oe, flash_quad);
		end
	end

	////////////////////
	// Helpers

	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Random burst length that never fills the last word
	function automatic int random_len();
		int l;
		l = int'((next_rand() >> 8) % 256) + 1;
		if (l % 4 == 0) begin
			l = l - 1;
		end
		return l;
	endfunction

	task automatic expect_equal(input word_t got, input word_t exp, input string what);
		assert (got === exp) else begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One APB transfer through setup and access phases
	task automatic bus_cycle(input logic write, input addr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
		int cycles;
		@(posedge apb);
		req.psel <= 1'b1;
		req.penable <= 1'b0;
		req.pwrite <= write;
		req.paddr <= addr;
		req.pwdata <= wdata;
		@(posedge apb);
		req.penable <= 1'b1;
		// Response sampled mid-cycle
		cycles = 0;
		@(negedge apb);
		while (!rsp.pready && cycles < TIMEOUT_CYCLES) begin
			@(negedge apb);
			cycles++;
		end
		if (!rsp.pready) begin
			timeouts++;
			$display("APB transfer to %h never completed, pready stayed low", addr);
		end
		rdata = rsp.prdata;
		err = rsp.pslverr;
		@(posedge apb);
		req.psel <= 1'b0;
		req.penable <= 1'b0;
	endtask

	task automatic write_expect(input addr_t addr, input word_t data, input logic exp_err,
		input string what);
		word_t rdata;
		logic err;
		bus_cycle(1'b1, addr, data, rdata, err);
		expect_equal(word_t'(err), word_t'(exp_err), {what, " pslverr"});
	endtask

	task automatic read_expect(input addr_t addr, input word_t exp, input string what);
		word_t rdata;
		logic err;
		bus_cycle(1'b0, addr, '0, rdata, err);
		expect_equal(word_t'(err), 32'd0, {what, " pslverr"});
		expect_equal(rdata, exp, what);
	endtask

	// Poll status until busy clears
	task automatic wait_idle(input string what);
		word_t status;
		logic err;
		int polls;
		polls = 0;
		bus_cycle(1'b0, REG_STATUS, '0, status, err);
		while (status[0] && polls < IDLE_POLLS) begin
			bus_cycle(1'b0, REG_STATUS, '0, status, err);
			polls++;
		end
		if (status[0]) begin
			timeouts++;
			$display("%s never finished, status busy stayed set", what);
		end
	endtask

	// Chip select toggle restarts the flash byte sequence
	task automatic select_flash(input logic quad);
		flash_quad <= quad;
		write_expect(REG_CS_N, 32'd1, 1'b0, "deselect");
		write_expect(REG_CS_N, 32'd0, 1'b0, "select");
	endtask

	task automatic check_burst(input addr_t len_reg, input logic quad, input int len,
		input string what);
		int words;
		int j;
		word_t exp;
		select_flash(quad);
		write_expect(len_reg, word_t'(len), 1'b0, {what, " start"});
		wait_idle(what);
		expect_equal(word_t'(flash_bytes), word_t'(len), {what, " byte count"});
		// Little endian words with zero past the last byte
		words = (len + 3) / 4;
		for (int w = 0; w < words; w++) begin
			exp = '0;
			for (int b = 0; b < 4; b++) begin
				j = 4 * w + b;
				if (j < len) begin
					exp = exp | (word_t'(byte_t'(j) ^ 8'hA5) << (8 * b));
				end
			end
			read_expect(REG_RXBUF + addr_t'(4 * w), exp, {what, " buffer word"});
		end
	endtask

	////////////////////
	// Stimulus

	initial begin
		word_t rdata;
		logic err;
		word_t div;
		byte_t tx;
		int len;
		int rises;

		rst_n = 1'b0;
		req = '0;
		flash_quad = 1'b0;
		repeat (16) @(posedge apb);
		rst_n <= 1'b1;
		@(negedge apb);

		// Reset state
		expect_equal(word_t'(qspi.cs_n), 32'd1, "cs_n after reset");
		expect_equal(word_t'(qspi.sck), 32'd0, "sck after reset");
		expect_equal(word_t'(qspi.dq_oe), 32'd0, "dq_oe after reset");
		read_expect(REG_STATUS, 32'd0, "status after reset");
		read_expect(REG_CLK_DIV, word_t'(DIV_RESET), "divider reset value");
		read_expect(REG_QUAD_CAP, 32'd1, "quad capability");

		// Divider, chip select and error responses
		div = next_rand() >> 16;
		write_expect(REG_CLK_DIV, div, 1'b0, "divider write");
		read_expect(REG_CLK_DIV, div, "divider readback");
		write_expect(REG_CS_N, 32'd0, 1'b0, "cs_n write 0");
		@(negedge apb);
		expect_equal(word_t'(qspi.cs_n), 32'd0, "cs_n pin low");
		write_expect(REG_CS_N, 32'd1, 1'b0, "cs_n write 1");
		@(negedge apb);
		expect_equal(word_t'(qspi.cs_n), 32'd1, "cs_n pin high");
		bus_cycle(1'b0, 9'h080, '0, rdata, err);
		expect_equal(word_t'(err), 32'd1, "unmapped read pslverr");
		write_expect(9'h084, 32'hDEAD_BEEF, 1'b1, "unmapped write");
		write_expect(REG_STATUS, 32'd1, 1'b1, "status write");

		// Single byte on a single lane
		write_expect(REG_CLK_DIV, word_t'(2 + (next_rand() >> 8) % 4), 1'b0,
			"transfer divider");
		select_flash(1'b0);
		tx = byte_t'(next_rand() >> 24);
		write_expect(REG_DATA, word_t'(tx), 1'b0, "DATA write");
		read_expect(REG_STATUS, 32'd1, "status busy during transfer");
		write_expect(REG_DATA, word_t'(~tx), 1'b1, "DATA write while busy");
		wait_idle("single transfer");
		expect_equal(word_t'(flash_bytes), 32'd1, "single transfer byte count");
		expect_equal(word_t'(flash_mosi), word_t'(tx), "MOSI byte at flash");
		read_expect(REG_DATA, 32'h0000_00A5, "DATA readback");

		// Bursts in both lane modes
		write_expect(REG_CLK_DIV, 32'd2, 1'b0, "burst divider");
		len = random_len();
		check_burst(REG_BURST_RDLEN, 1'b0, len, "single-lane burst");
		len = random_len();
		check_burst(REG_QBURST_RDLEN, 1'b1, len, "quad burst");

		// Oversized length clamps to 256
		len = 257 + int'((next_rand() >> 8) % 700);
		select_flash(1'b0);
		write_expect(REG_BURST_RDLEN, word_t'(len), 1'b0, "oversized burst start");
		wait_idle("oversized burst");
		expect_equal(word_t'(flash_bytes), 32'd256, "oversized burst clamped");

		// Zero length starts nothing
		rises = sck_rises;
		write_expect(REG_BURST_RDLEN, 32'd0, 1'b0, "zero-length burst write");
		read_expect(REG_STATUS, 32'd0, "status after zero-length burst");
		repeat (40) @(posedge apb);
		expect_equal(word_t'(sck_rises), word_t'(rises), "SCK edges on zero length");

		$display("check errors: %0d, dq_oe errors: %0d, timeouts: %0d",
			check_errors, oe_errors, timeouts);
		if (check_errors == 0 && oe_errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
src/qspi_pkg.sv
src/qspi_regs.sv
src/qspi_burst_capture.sv
src/qspi_shifter.sv
src/qspi_host.sv
dv/qspi_flash_model.sv
dv/qspi_host_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= qspi_host_tb
RTL_TOP ?= qspi_host
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
